//--- Makefile
VERILATOR ?= verilator
TOP       ?= mipsCpuBusTb
FLAGS     ?= --assert
FILELIST  ?= filelist.f
OBJDIR    ?= obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "ALL TESTS PASSED"

clean:
	rm -rf $(OBJDIR)

//--- dv/avalonRam.sv
// Avalon slave word memory
module avalonRam (
    input  logic          clk,
    input  mipsPkg::wordT address,
    input  logic          read,
    input  logic          write,
    input  mipsPkg::wordT writedata,
    input  logic [3:0]    byteenable,
    output logic          waitrequest,
    output mipsPkg::wordT readdata
);
    import mipsPkg::*;

    wordT        mem [wordT]; // Sparse map keyed by byte address
    int          reads;       // Accepted reads
    int          writes;      // Accepted writes
    int          stallRun;    // Consecutive stalled cycles
    logic [31:0] rnd;

    // Xorshift step for the stall pattern
    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    initial begin
        waitrequest = 1'b0;
        readdata    = '0;
        reads       = 0;
        writes      = 0;
        stallRun    = 0;
        rnd         = 32'hc627;
        forever begin
            @(posedge clk);
            if (write && !waitrequest && (byteenable == WORD_ENABLE)) begin
                mem[address] = writedata; // Every store lands here
                writes++;
            end
            if (read && !waitrequest) begin
                reads++;
            end
            #1;
            rnd         = xorshift(rnd);
            waitrequest = (stallRun < 3) && rnd[0]; // Runs capped at three cycles
            stallRun    = waitrequest ? stallRun + 1 : 0;
            // Zero latency keeps data ready before the accepting edge
            readdata    = mem.exists(address) ? mem[address] : '0;
        end
    end

endmodule

//--- dv/mipsCpuBusTb.sv
// Avalon MIPS CPU testbench
module mipsCpuBusTb;
    import mipsPkg::*;

    localparam wordT RESET_VECTOR = 32'hBFC00000;
    localparam int   PERIOD       = 4;

    logic       clk   = 1'b0;
    logic       reset = 1'b1;
    logic       waitrequest;
    wordT       readdata;
    logic       active;
    wordT       registerV0;
    wordT       address;
    logic       write;
    logic       read;
    wordT       writedata;
    logic [3:0] byteenable;

    int errors    = 0; // Mismatches in the running test
    int passCount = 0;
    int failCount = 0;
    int budget    = 0; // Cycles granted so far
    int cycles    = 0;

    mipsCpuBus #(.resetVector(RESET_VECTOR)) mipsCpuBus_i (
        .clk, .reset, .active, .registerV0, .address, .write, .read,
        .waitrequest, .writedata, .byteenable, .readdata
    );

    avalonRam avalonRam_i (
        .clk, .address, .read, .write, .writedata, .byteenable, .waitrequest, .readdata
    );

    initial begin
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Watchdog grants forty cycles per program word plus reset overhead
    initial begin
        while (cycles <= budget) begin
            @(posedge clk);
            cycles++;
        end
        $display("Watchdog expired after %0d cycles, a program never halted", cycles);
        $display("SOME TESTS FAILED");
        $finish;
    end

    task automatic checkWord(input string name, input wordT got, input wordT expected);
        if (got !== expected) begin
            $display("Error: %s is %h, expected %h", name, got, expected);
            errors++;
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            $display("Error: %s is %h, expected %h", name, got, expected);
            errors++;
        end
    endtask

    // Release reset, wait for halt, then inspect CPU and RAM
    task automatic runTest(input string name, input int words, input bit memCheck,
                           input wordT memAddr, input wordT memWord, input wordT expectV0);
        int   busAtHalt;
        wordT stored;
        budget += words * 40 + 16;
        repeat (4) @(posedge clk);
        #1 reset = 1'b0;
        while (active) begin
            @(posedge clk);
            #1;
        end
        busAtHalt = avalonRam_i.reads + avalonRam_i.writes;
        repeat (4) @(posedge clk); // Bus must stay quiet
        #1;
        checkBit("active", active, 1'b0);
        checkBit("read", read, 1'b0);
        checkBit("write", write, 1'b0);
        if (avalonRam_i.reads + avalonRam_i.writes != busAtHalt) begin
            $display("Bus transfer seen after the processor halted");
            errors++;
        end
        checkWord("registerV0", registerV0, expectV0);
        if (memCheck) begin
            stored = avalonRam_i.mem.exists(memAddr) ? avalonRam_i.mem[memAddr] : 'x;
            checkWord("ram word", stored, memWord);
        end
        if (errors == 0) begin
            passCount++;
            $display("Test %s passed", name);
        end else begin
            failCount++;
            $display("Test %s failed with %0d errors", name, errors);
        end
        errors = 0;
    endtask

    initial begin
        int    fd;
        string tok;
        string name;
        bit    inProg;   // Bare words are program words or data pairs
        int    words;
        bit    memCheck;
        wordT  value;
        wordT  addr;
        wordT  memAddr;
        wordT  memWord;
        wordT  expectV0;
        inProg   = 1'b0;
        words    = 0;
        memCheck = 1'b0;
        memAddr  = '0;
        memWord  = '0;
        expectV0 = '0;
        fd = $fopen("dv/testdata.txt", "r");
        if (fd == 0) begin
            $display("Cannot open dv/testdata.txt");
            failCount++;
        end else begin
            while ($fscanf(fd, "%s", tok) == 1) begin
                if (tok == "#") begin
                    void'($fgets(tok, fd)); // Rest of a comment line
                end else if (tok == "test") begin
                    void'($fscanf(fd, "%s", name));
                    reset = 1'b1; // Held until runTest
                    avalonRam_i.mem.delete();
                    inProg   = 1'b0;
                    words    = 0;
                    memCheck = 1'b0;
                end else if (tok == "prog") begin
                    inProg = 1'b1;
                end else if (tok == "data") begin
                    inProg = 1'b0;
                end else if (tok == "expect") begin
                    void'($fscanf(fd, "%h", expectV0));
                end else if (tok == "mem") begin
                    void'($fscanf(fd, "%h %h", memAddr, memWord));
                    memCheck = 1'b1;
                end else if (tok == "run") begin
                    runTest(name, words, memCheck, memAddr, memWord, expectV0);
                end else if (inProg) begin
                    void'($sscanf(tok, "%h", value));
                    avalonRam_i.mem[RESET_VECTOR + 4 * words] = value; // Word aligned
                    words++;
                end else begin
                    void'($sscanf(tok, "%h", addr));
                    void'($fscanf(fd, "%h", value));
                    avalonRam_i.mem[addr] = value;
                end
            end
            $fclose(fd);
        end
        $display("%0d tests passed, %0d tests failed", passCount, failCount);
        if ((failCount == 0) && (passCount > 0)) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- dv/testdata.txt
# Tokens: test <name>, prog <words from the reset vector>, data <address word> pairs,
# expect <registerV0>, mem <address word> checked after halt, run starts the test
test alu expect 0000A03F
prog 24011234 2403FFFF 3C04ABCD 34845678 00812821 00A32823 00A41024 00411025
prog 00431026 3042F0F0 384200FF 00000008 run
test compare expect 0000000B
prog 2401FFF8 24030005 0023202A 0023282B 2C66FFFF 28270003 000420C0 00052880
prog 00063040 00851025 00461025 00471025 00000008 run
test shifts expect 00F0F01E
prog 3C018000 34210F00 2403000C 00012100 00012A02 00013203 00613804 00614006
prog 00614807 00851021 00461021 00471021 00481021 00491021 00000008 run
test memory expect DD334685 mem 00001008 CAFEF00D data 00001010 12345678
prog 24011000 3C03CAFE 3463F00D AC230008 8C240010 8C220008 00441021 00000008 run
test branch expect 00000326
prog 24010005 24030005 10230001 34420001 14230001 34420002 10200001 34420004
prog 14200001 34420008 0BF0000C 34420010 34420020 24050003 24420100 24A5FFFF
prog 14A0FFFD 00000008 run
test zeroreg expect 00000000
prog 24020077 24000055 3C00FFFF 00001021 00000008 run

//--- filelist.f
logic/mipsPkg.sv
logic/busSequencer.sv
logic/registerFile.sv
logic/executeUnit.sv
logic/mipsCpuBus.sv
dv/avalonRam.sv
dv/mipsCpuBusTb.sv

//--- logic/busSequencer.sv
// Bus sequencer and Avalon master
module busSequencer #(
    parameter mipsPkg::wordT resetVector = 32'hBFC00000
) (
    input  logic              clk,
    input  logic              reset,
    // Avalon master
    output mipsPkg::wordT     address,
    output logic              read,
    output logic              write,
    output mipsPkg::wordT     writedata,
    output logic [3:0]        byteenable,
    input  logic              waitrequest,
    input  mipsPkg::wordT     readdata,
    output logic              active,
    // Towards execute unit
    output mipsPkg::wordT     instr,
    output mipsPkg::wordT     pc,
    output logic              execute,
    // Back from execute unit, sampled in EXEC
    input  mipsPkg::wordT     nextPc,
    input  logic              memRead,
    input  logic              memWrite,
    input  mipsPkg::wordT     memAddr,
    input  mipsPkg::wordT     storeData,
    input  mipsPkg::regIndexT loadReg,
    // Register file load port
    output logic              loadWe,
    output mipsPkg::regIndexT loadAddr,
    output mipsPkg::wordT     loadData
);
    import mipsPkg::*;

    stateT    state;
    logic     started;    // Keeps the bus idle in the first cycle out of reset
    logic     accepted;   // Transfer completes on this edge
    logic     memReadQ;   // Latched load request
    logic     memWriteQ;  // Latched store request
    wordT     memAddrQ;
    wordT     storeDataQ;
    regIndexT loadRegQ;
    wordT     nextPcQ;    // Applied once MEM finishes

    // Avalon outputs come straight from state and latched request
    assign read       = ((state == FETCH) && started) || ((state == MEM) && memReadQ);
    assign write      = (state == MEM) && memWriteQ;
    assign address    = (state == MEM) ? memAddrQ : pc; // Data address or fetch address
    assign writedata  = storeDataQ;
    assign byteenable = (read || write) ? WORD_ENABLE : 4'b0000;
    assign accepted   = (read || write) && !waitrequest;

    assign active  = (state != HALT);
    assign execute = (state == EXEC); // One cycle per instruction

    // Zero read latency, so the load lands on the accepting edge
    assign loadWe   = (state == MEM) && memReadQ && !waitrequest;
    assign loadAddr = loadRegQ;
    assign loadData = readdata;

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= FETCH;
            pc        <= resetVector;
            started   <= 1'b0;
            memReadQ  <= 1'b0;
            memWriteQ <= 1'b0;
        end else begin
            started <= 1'b1;
            case (state)
                FETCH: begin
                    if (accepted) begin
                        state <= EXEC;
                    end
                end
                EXEC: begin
                    memReadQ  <= memRead;
                    memWriteQ <= memWrite;
                    if (memRead || memWrite) begin
                        state <= MEM; // PC update waits for the data transfer
                    end else if (nextPc == '0) begin
                        state <= HALT;
                    end else begin
                        pc    <= nextPc;
                        state <= FETCH;
                    end
                end
                MEM: begin
                    if (accepted) begin
                        memReadQ  <= 1'b0;
                        memWriteQ <= 1'b0;
                        if (nextPcQ == '0) begin
                            state <= HALT;
                        end else begin
                            pc    <= nextPcQ;
                            state <= FETCH;
                        end
                    end
                end
                default: state <= HALT; // Stays until reset
            endcase
        end
    end

    // Instruction and request payload
    always_ff @(posedge clk) begin
        if ((state == FETCH) && accepted) begin
            instr <= readdata;
        end
        if (execute) begin
            memAddrQ   <= memAddr;
            storeDataQ <= storeData;
            loadRegQ   <= loadReg;
            nextPcQ    <= nextPc;
        end
    end

    // Stalled request holds address and command until accepted
    assert property (@(posedge clk) disable iff (reset)
        (read || write) && waitrequest |=> $stable(address) && $stable(read) && $stable(write));

    // Single transfer type at a time
    assert property (@(posedge clk) disable iff (reset) !(read && write));

endmodule

//--- logic/executeUnit.sv
// Decoder, ALU and next PC logic
module executeUnit (
    input  mipsPkg::wordT     instr,
    input  mipsPkg::wordT     pc,
    input  logic              execute,
    // Register file read ports
    output mipsPkg::regIndexT rsAddr,
    output mipsPkg::regIndexT rtAddr,
    input  mipsPkg::wordT     rsData,
    input  mipsPkg::wordT     rtData,
    // Register file ALU write port
    output logic              aluWe,
    output mipsPkg::regIndexT aluAddr,
    output mipsPkg::wordT     aluData,
    // Control flow and memory request
    output mipsPkg::wordT     nextPc,
    output logic              memRead,
    output logic              memWrite,
    output mipsPkg::wordT     memAddr,
    output mipsPkg::wordT     storeData,
    output mipsPkg::regIndexT loadReg
);
    import mipsPkg::*;

    opcodeT      opcode;
    functT       funct;
    regIndexT    rd;
    logic [4:0]  shamt;
    logic [15:0] imm;
    logic [25:0] target;
    wordT        signExtImm;
    wordT        zeroExtImm; // Logical immediates only
    wordT        pcPlus4;
    wordT        branchTarget;
    logic        writeEn;    // Instruction produces a register result

    // Instruction fields
    assign opcode = opcodeT'(instr[31:26]);
    assign rsAddr = instr[25:21];
    assign rtAddr = instr[20:16];
    assign rd     = instr[15:11];
    assign shamt  = instr[10:6];
    assign funct  = functT'(instr[5:0]);
    assign imm    = instr[15:0];
    assign target = instr[25:0];

    assign signExtImm   = {{16{imm[15]}}, imm};
    assign zeroExtImm   = {16'h0000, imm};
    assign pcPlus4      = pc + 32'd4;
    assign branchTarget = pcPlus4 + {signExtImm[29:0], 2'b00}; // No delay slot

    // LW and SW share base plus offset
    assign memAddr   = rsData + signExtImm;
    assign storeData = rtData;
    assign loadReg   = rtAddr;

    // Register file only commits on the EXEC cycle
    assign aluWe = execute && writeEn;

    always_comb begin
        writeEn  = 1'b0;
        aluAddr  = rtAddr; // I-type target by default
        aluData  = '0;
        nextPc   = pcPlus4;
        memRead  = 1'b0;
        memWrite = 1'b0;
        case (opcode)
            OPCODE_R: begin
                aluAddr = rd;
                writeEn = 1'b1;
                case (funct)
                    FUNCT_ADDU: aluData = rsData + rtData;
                    FUNCT_SUBU: aluData = rsData - rtData;
                    FUNCT_AND:  aluData = rsData & rtData;
                    FUNCT_OR:   aluData = rsData | rtData;
                    FUNCT_XOR:  aluData = rsData ^ rtData;
                    FUNCT_SLT:  aluData = {31'b0, $signed(rsData) < $signed(rtData)};
                    FUNCT_SLTU: aluData = {31'b0, rsData < rtData};
                    FUNCT_SLL:  aluData = rtData << shamt;
                    FUNCT_SRL:  aluData = rtData >> shamt;
                    FUNCT_SRA:  aluData = $signed(rtData) >>> shamt;
                    FUNCT_SLLV: aluData = rtData << rsData[4:0];
                    FUNCT_SRLV: aluData = rtData >> rsData[4:0];
                    FUNCT_SRAV: aluData = $signed(rtData) >>> rsData[4:0];
                    FUNCT_JR: begin
                        writeEn = 1'b0;
                        nextPc  = rsData; // Zero here halts the sequencer
                    end
                    default: writeEn = 1'b0; // Unknown funct is a no-op
                endcase
            end
            OPCODE_J: nextPc = {pc[31:28], target, 2'b00}; // Region of the current PC
            OPCODE_BEQ: begin
                if (rsData == rtData) begin
                    nextPc = branchTarget;
                end
            end
            OPCODE_BNE: begin
                if (rsData != rtData) begin
                    nextPc = branchTarget;
                end
            end
            OPCODE_ADDIU: begin
                writeEn = 1'b1;
                aluData = rsData + signExtImm;
            end
            OPCODE_SLTI: begin
                writeEn = 1'b1;
                aluData = {31'b0, $signed(rsData) < $signed(signExtImm)};
            end
            OPCODE_SLTIU: begin
                writeEn = 1'b1;
                aluData = {31'b0, rsData < signExtImm}; // Sign-extended then compared unsigned
            end
            OPCODE_ANDI: begin
                writeEn = 1'b1;
                aluData = rsData & zeroExtImm;
            end
            OPCODE_ORI: begin
                writeEn = 1'b1;
                aluData = rsData | zeroExtImm;
            end
            OPCODE_XORI: begin
                writeEn = 1'b1;
                aluData = rsData ^ zeroExtImm;
            end
            OPCODE_LUI: begin
                writeEn = 1'b1;
                aluData = {imm, 16'h0000};
            end
            OPCODE_LW: memRead = 1'b1;  // Result written by the sequencer
            OPCODE_SW: memWrite = 1'b1;
            default: ;                  // Unknown opcode falls through to PC plus 4
        endcase
    end

endmodule

//--- logic/mipsCpuBus.sv
// Multi-cycle MIPS CPU with Avalon master
module mipsCpuBus #(
    parameter mipsPkg::wordT resetVector = 32'hBFC00000
) (
    input  logic          clk,
    input  logic          reset,
    output logic          active,
    output mipsPkg::wordT registerV0,
    // Avalon memory-mapped master
    output mipsPkg::wordT address,
    output logic          write,
    output logic          read,
    input  logic          waitrequest,
    output mipsPkg::wordT writedata,
    output logic [3:0]    byteenable,
    input  mipsPkg::wordT readdata
);
    import mipsPkg::*;

    wordT     instr;
    wordT     pc;
    logic     execute;
    wordT     nextPc;
    logic     memRead;
    logic     memWrite;
    wordT     memAddr;
    wordT     storeData;
    regIndexT loadReg;
    regIndexT rsAddr;
    regIndexT rtAddr;
    wordT     rsData;
    wordT     rtData;
    logic     aluWe;
    regIndexT aluAddr;
    wordT     aluData;
    logic     loadWe;
    regIndexT loadAddr;
    wordT     loadData;

    // Producer that fetches instructions and moves load and store data
    busSequencer #(
        .resetVector(resetVector)
    ) busSequencer_i (
        .clk, .reset, .address, .read, .write, .writedata, .byteenable,
        .waitrequest, .readdata, .active, .instr, .pc, .execute,
        .nextPc, .memRead, .memWrite, .memAddr, .storeData, .loadReg,
        .loadWe, .loadAddr, .loadData
    );

    // Buffer between the two
    registerFile registerFile_i (
        .clk, .reset, .rsAddr, .rtAddr, .rsData, .rtData,
        .aluWe, .aluAddr, .aluData, .loadWe, .loadAddr, .loadData, .registerV0
    );

    // Consumer that decodes and executes one instruction per EXEC cycle
    executeUnit executeUnit_i (
        .instr, .pc, .execute, .rsAddr, .rtAddr, .rsData, .rtData,
        .aluWe, .aluAddr, .aluData, .nextPc, .memRead, .memWrite,
        .memAddr, .storeData, .loadReg
    );

endmodule

//--- logic/mipsPkg.sv
// MIPS shared definitions
package mipsPkg;

    typedef logic [31:0] wordT;     // Data and address word
    typedef logic [4:0]  regIndexT; // Register number

    // Primary opcode, instr[31:26]
    typedef enum logic [5:0] {
        OPCODE_R     = 6'd0,  // Decoded further by funct
        OPCODE_J     = 6'd2,
        OPCODE_BEQ   = 6'd4,
        OPCODE_BNE   = 6'd5,
        OPCODE_ADDIU = 6'd9,
        OPCODE_SLTI  = 6'd10,
        OPCODE_SLTIU = 6'd11,
        OPCODE_ANDI  = 6'd12,
        OPCODE_ORI   = 6'd13,
        OPCODE_XORI  = 6'd14,
        OPCODE_LUI   = 6'd15,
        OPCODE_LW    = 6'd35,
        OPCODE_SW    = 6'd43
    } opcodeT;

    // R-type function code, instr[5:0]
    typedef enum logic [5:0] {
        FUNCT_SLL  = 6'd0,
        FUNCT_SRL  = 6'd2,
        FUNCT_SRA  = 6'd3,
        FUNCT_SLLV = 6'd4,
        FUNCT_SRLV = 6'd6,
        FUNCT_SRAV = 6'd7,
        FUNCT_JR   = 6'd8,
        FUNCT_ADDU = 6'd33,
        FUNCT_SUBU = 6'd35,
        FUNCT_AND  = 6'd36,
        FUNCT_OR   = 6'd37,
        FUNCT_XOR  = 6'd38,
        FUNCT_SLT  = 6'd42,
        FUNCT_SLTU = 6'd43
    } functT;

    // Sequencer states
    typedef enum logic [1:0] {
        FETCH = 2'd0, // Instruction read on the bus
        EXEC  = 2'd1, // Single decode and ALU cycle
        MEM   = 2'd2, // Data load or store on the bus
        HALT  = 2'd3  // Parked until reset
    } stateT;

    // Hardwired zero register
    localparam regIndexT REG_ZERO = 5'd0;

    // Result register exposed at the top level
    localparam regIndexT REG_V0 = 5'd2;

    // All four byte lanes of a word transfer
    localparam logic [3:0] WORD_ENABLE = 4'b1111;

endpackage

//--- logic/registerFile.sv
// General purpose register file
module registerFile (
    input  logic              clk,
    input  logic              reset,
    input  mipsPkg::regIndexT rsAddr,
    input  mipsPkg::regIndexT rtAddr,
    output mipsPkg::wordT     rsData,
    output mipsPkg::wordT     rtData,
    // ALU result port used in EXEC only
    input  logic              aluWe,
    input  mipsPkg::regIndexT aluAddr,
    input  mipsPkg::wordT     aluData,
    // Load result port used in MEM only
    input  logic              loadWe,
    input  mipsPkg::regIndexT loadAddr,
    input  mipsPkg::wordT     loadData,
    output mipsPkg::wordT     registerV0
);
    import mipsPkg::*;

    wordT regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (aluWe && (aluAddr != REG_ZERO)) begin
                regs[aluAddr] <= aluData;
            end
            if (loadWe && (loadAddr != REG_ZERO)) begin
                regs[loadAddr] <= loadData;
            end
        end
    end

    // Register zero is never written, so it reads as zero
    assign rsData     = regs[rsAddr];
    assign rtData     = regs[rtAddr];
    assign registerV0 = regs[REG_V0];

    // Sequencer keeps ALU and load writes in separate states
    assert property (@(posedge clk) disable iff (reset) !(aluWe && loadWe));

endmodule
